// File: list.f
+incdir+source
source/quiz_pkg.sv
source/answer_entry.sv
source/answer_judge.sv
source/game_ctrl.sv
source/seg_display.sv
source/quiz_top.sv
tests/quiz_assertions.sv
tests/quiz_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= quiz_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/quiz_tb.sv
`include "quiz_consts.svh"

module quiz_tb;

  localparam int N_ROUNDS = 12;
  // worst round with some margin
  localparam int ROUND_CYCLES = 400;

  logic CLK;
  logic rst;
  logic start;
  logic [2:0] sel;
  logic clr;
  logic dec;
  logic q_valid;
  logic [15:0] q_data;
  logic q_credit;
  quiz_pkg::game_state_t state;
  logic [1:0] tries;
  logic [1:0] hits;
  logic led;
  logic [3:0] seg1, seg2, seg3, seg4, seg5, seg6;
  logic [3:0] seg_q1, seg_q2, seg_q3, seg_lvl;

  int n_mismatch;
  int n_other;
  int m_tries;
  // model digit counters and their values one step back
  logic [3:0] m1, m2, m3;
  logic [3:0] p1, p2, p3;
  // question held by the store model for this round
  logic [15:0] q;

  quiz_top quiz_top_inst (
    .CLK(CLK), .rst(rst), .start(start), .sel(sel), .clr(clr), .dec(dec),
    .q_valid(q_valid), .q_data(q_data), .q_credit(q_credit), .state(state),
    .tries(tries), .hits(hits), .led(led),
    .seg1(seg1), .seg2(seg2), .seg3(seg3), .seg4(seg4), .seg5(seg5), .seg6(seg6),
    .seg_q1(seg_q1), .seg_q2(seg_q2), .seg_q3(seg_q3), .seg_lvl(seg_lvl)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // hard stop sized for the worst round
  initial begin
    repeat (N_ROUNDS * ROUND_CYCLES + 20) @(posedge CLK);
    $display("timeout: the rounds did not finish in %0d cycles", N_ROUNDS * ROUND_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  task automatic report_mismatch(input string name, input logic [3:0] got,
                                 input logic [3:0] exp);
    $display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
    n_mismatch++;
  endtask

  task automatic report_error(input string what);
    $display("error at %0t: %s", $time, what);
    n_other++;
  endtask

  // a press turns a blank into 1, and 9 back into 1
  function automatic logic [3:0] next_digit(input logic [3:0] d);
    return (d == 4'd0 || d >= 4'd9) ? 4'd1 : d + 4'd1;
  endfunction

  // miss forces a wrong digit, otherwise mostly the right one
  function automatic logic [3:0] pick_target(input logic [3:0] d, input bit miss);
    if (miss)
      return next_digit(d);
    return ($urandom_range(0, 2) != 0) ? d : 4'($urandom_range(1, 9));
  endfunction

  task automatic wait_state(input logic [3:0] target, input int limit);
    int n;
    n = 0;
    while (state !== target && n < limit) begin
      @(negedge CLK);
      n++;
    end
    if (state !== target)
      report_error($sformatf("state %h not reached within %0d cycles", target, limit));
  endtask

  task automatic check_answer_segs(input logic [3:0] a, input logic [3:0] b,
                                   input logic [3:0] c);
    if (seg1 !== a) report_mismatch("seg1", seg1, a);
    if (seg2 !== a) report_mismatch("seg2", seg2, a);
    if (seg3 !== b) report_mismatch("seg3", seg3, b);
    if (seg4 !== b) report_mismatch("seg4", seg4, b);
    if (seg5 !== c) report_mismatch("seg5", seg5, c);
    if (seg6 !== c) report_mismatch("seg6", seg6, c);
  endtask

  // ones digit in the low nibble and only two level bits shown
  task automatic check_question_segs(input logic [15:0] v);
    if (seg_q1 !== v[3:0]) report_mismatch("seg_q1", seg_q1, v[3:0]);
    if (seg_q2 !== v[7:4]) report_mismatch("seg_q2", seg_q2, v[7:4]);
    if (seg_q3 !== v[11:8]) report_mismatch("seg_q3", seg_q3, v[11:8]);
    if (seg_lvl !== {2'b00, v[13:12]}) report_mismatch("seg_lvl", seg_lvl, {2'b00, v[13:12]});
  endtask

  // one INPUT cycle where the segs trail the counters by one step
  task automatic press(input logic [2:0] s, input logic c);
    if (state !== quiz_pkg::INPUT) report_mismatch("state", state, quiz_pkg::INPUT);
    check_answer_segs(p1, p2, p3);
    p1 = m1;
    p2 = m2;
    p3 = m3;
    sel = s;
    clr = c;
    // sel[0] first, clr last
    if (s[0])
      m1 = next_digit(m1);
    else if (s[1])
      m2 = next_digit(m2);
    else if (s[2])
      m3 = next_digit(m3);
    else if (c) begin
      m1 = 4'd0;
      m2 = 4'd0;
      m3 = 4'd0;
    end
    @(negedge CLK);
    sel = 3'b000;
    clr = 1'b0;
  endtask

  // result state length, zeroed segs and a steady try count
  task automatic hold_result(input logic [3:0] exp_st);
    int n;
    n = 0;
    while (state === exp_st && n < 40) begin
      if (tries !== 2'(m_tries)) report_mismatch("tries", 4'(tries), 4'(m_tries));
      if (n > 0) check_answer_segs(4'd0, 4'd0, 4'd0);
      @(negedge CLK);
      n++;
    end
    if (n != `QZ_RESULT_CYCLES)
      report_error($sformatf("result state %h held %0d cycles instead of %0d",
                             exp_st, n, `QZ_RESULT_CYCLES));
  endtask

  task automatic run_round();
    int n_cred;
    int n_show;
    int h;
    bit done;
    bit miss;
    logic [3:0] exp_st;
    logic [3:0] t1, t2, t3;
    wait_state(quiz_pkg::IDLE, 40);
    if (led !== 1'b0) report_mismatch("led", 4'(led), 4'h0);
    start = 1'b1;
    @(negedge CLK);
    start = 1'b0;
    if (state !== quiz_pkg::FETCH) report_mismatch("state", state, quiz_pkg::FETCH);
    // store model with random upper level bits too
    q = {4'($urandom), 4'($urandom_range(1, 9)), 4'($urandom_range(1, 9)),
         4'($urandom_range(1, 9))};
    n_cred = 0;
    repeat ($urandom_range(1, 6)) begin
      if (q_credit === 1'b1) n_cred++;
      @(negedge CLK);
    end
    q_valid = 1'b1;
    q_data = q;
    if (q_credit === 1'b1) n_cred++;
    @(negedge CLK);
    // sometimes a stray repeat with other data and no credit behind it
    q_valid = 1'($urandom);
    q_data = ~q;
    if (q_credit === 1'b1) n_cred++;
    @(negedge CLK);
    q_valid = 1'b0;
    n_show = 0;
    while (state === quiz_pkg::QUESTION && n_show < 40) begin
      if (n_show > 0) check_question_segs(q);
      @(negedge CLK);
      n_show++;
    end
    if (n_cred != 1)
      report_error($sformatf("%0d question credits seen in FETCH, expected 1", n_cred));
    if (n_show != (`QZ_SHOW_BASE >> q[13:12]))
      report_error($sformatf("question shown %0d cycles, expected %0d",
                             n_show, `QZ_SHOW_BASE >> q[13:12]));
    m_tries = 0;
    done = 1'b0;
    while (!done) begin
      m1 = 4'd0;
      m2 = 4'd0;
      m3 = 4'd0;
      p1 = 4'd0;
      p2 = 4'd0;
      p3 = 4'd0;
      if (led !== 1'b1) report_mismatch("led", 4'(led), 4'h1);
      // question still on the display for one INPUT cycle
      if (m_tries == 0) check_question_segs(q);
      repeat ($urandom_range(2, 12)) press(3'($urandom), ($urandom_range(0, 7) == 0));
      check_question_segs(16'h0000);
      // steer toward the question with some tries off on purpose
      miss = ($urandom_range(0, 3) == 0);
      t1 = pick_target(q[3:0], miss);
      t2 = pick_target(q[7:4], miss);
      t3 = pick_target(q[11:8], miss);
      while (m1 != t1 || m2 != t2 || m3 != t3) begin
        if (m1 != t1)
          press(3'b001, 1'b0);
        else if (m2 != t2)
          press(3'b010, 1'b0);
        else
          press(3'b100, 1'b0);
      end
      h = 0;
      if (m1 == q[3:0]) h++;
      if (m2 == q[7:4]) h++;
      if (m3 == q[11:8]) h++;
      check_answer_segs(p1, p2, p3);
      dec = 1'b1;
      @(negedge CLK);
      // second dec while the answer credit is out
      dec = 1'($urandom);
      @(negedge CLK);
      dec = 1'b0;
      m_tries++;
      exp_st = (h == 3) ? quiz_pkg::WIN : ((h == 0) ? quiz_pkg::OUCH : quiz_pkg::GOOD);
      if (state !== exp_st) report_mismatch("state", state, exp_st);
      if (hits !== 2'(h)) report_mismatch("hits", 4'(hits), 4'(h));
      hold_result(exp_st);
      if (h == 3) begin
        done = 1'b1;
      end else if (m_tries >= `QZ_MAX_TRIES) begin
        if (state !== quiz_pkg::LOSE) report_mismatch("state", state, quiz_pkg::LOSE);
        hold_result(quiz_pkg::LOSE);
        done = 1'b1;
      end
    end
    if (state !== quiz_pkg::IDLE) report_mismatch("state", state, quiz_pkg::IDLE);
    if (led !== 1'b0) report_mismatch("led", 4'(led), 4'h0);
  endtask

  initial begin
    void'($urandom(32'h5be7_236d));
    n_mismatch = 0;
    n_other = 0;
    rst = 1'b1;
    start = 1'b0;
    sel = 3'b000;
    clr = 1'b0;
    dec = 1'b0;
    q_valid = 1'b0;
    q_data = 16'h0000;
    repeat (10) @(negedge CLK);
    rst = 1'b0;
    // reset values
    if (state !== quiz_pkg::IDLE) report_mismatch("state", state, quiz_pkg::IDLE);
    if (led !== 1'b0) report_mismatch("led", 4'(led), 4'h0);
    if (q_credit !== 1'b0) report_mismatch("q_credit", 4'(q_credit), 4'h0);
    check_answer_segs(4'd0, 4'd0, 4'd0);
    check_question_segs(16'h0000);
    repeat (N_ROUNDS) run_round();
    $display("checks done: %0d mismatches, %0d other errors", n_mismatch, n_other);
    if (n_mismatch + n_other == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: tests/quiz_assertions.sv
module quiz_assertions (
  input logic                   CLK,
  input logic                   rst,
  input quiz_pkg::game_state_t  state,
  input logic                   q_credit,
  input logic                   q_loaded,
  input logic                   ans_valid,
  input logic                   ans_credit
);

  // question credit sent and not yet used up by a load
  logic q_owed;
  // answer credit out at the judge
  logic ans_out;

  always_ff @(posedge CLK) begin
    if (rst) begin
      q_owed <= 1'b0;
    end else if (q_credit) begin
      q_owed <= 1'b1;
    end else if (q_loaded) begin
      q_owed <= 1'b0;
    end
  end

  // spent by a submit, home again on the judge's return
  always_ff @(posedge CLK) begin
    if (rst) begin
      ans_out <= 1'b0;
    end else if (ans_valid) begin
      ans_out <= 1'b1;
    end else if (ans_credit) begin
      ans_out <= 1'b0;
    end
  end

  // credit only in the first FETCH cycle
  credit_on_entry: assert property (@(posedge CLK) disable iff (rst)
    q_credit |-> (state == quiz_pkg::FETCH) && ($past(state) == quiz_pkg::IDLE))
    else $error("question credit outside entry to FETCH");

  // and every entry to FETCH carries one
  entry_has_credit: assert property (@(posedge CLK) disable iff (rst)
    (state == quiz_pkg::FETCH) && ($past(state) != quiz_pkg::FETCH) |-> q_credit)
    else $error("FETCH entered without a question credit");

  // answer goes out only while the credit is back from the judge
  answer_needs_credit: assert property (@(posedge CLK) disable iff (rst)
    ans_valid |-> !ans_out)
    else $error("answer sent without a credit");

  // each load uses up one credit so a repeat q_valid must not load
  repeat_dropped: assert property (@(posedge CLK) disable iff (rst)
    q_loaded |-> q_owed)
    else $error("second question accepted without a new credit");

endmodule

// controller side with the answer ports tied low
bind game_ctrl quiz_assertions game_ctrl_checks (
  .CLK(CLK), .rst(rst), .state(state), .q_credit(q_credit), .q_loaded(q_loaded),
  .ans_valid(1'b0), .ans_credit(1'b0)
);

// entry side with state held at IDLE and no question traffic
bind answer_entry quiz_assertions answer_entry_checks (
  .CLK(CLK), .rst(rst), .state(quiz_pkg::IDLE), .q_credit(1'b0), .q_loaded(1'b0),
  .ans_valid(ans_valid), .ans_credit(ans_credit)
);

// File: source/quiz_top.sv
module quiz_top (
  input  logic                   CLK,
  input  logic                   rst,
  input  logic                   start,
  input  logic [2:0]             sel,
  input  logic                   clr,
  input  logic                   dec,
  input  logic                   q_valid,
  input  logic [15:0]            q_data,
  output logic                   q_credit,
  output quiz_pkg::game_state_t  state,
  output logic [1:0]             tries,
  output logic [1:0]             hits,
  output logic                   led,
  output logic [3:0]             seg1,
  output logic [3:0]             seg2,
  output logic [3:0]             seg3,
  output logic [3:0]             seg4,
  output logic [3:0]             seg5,
  output logic [3:0]             seg6,
  output logic [3:0]             seg_q1,
  output logic [3:0]             seg_q2,
  output logic [3:0]             seg_q3,
  output logic [3:0]             seg_lvl
);

  // entry side
  logic [3:0] cnt1;
  logic [3:0] cnt2;
  logic [3:0] cnt3;
  logic [1:0] q_level;
  logic [3:0] q_d1;
  logic [3:0] q_d2;
  logic [3:0] q_d3;
  logic       q_loaded;
  // answer path to the judge
  logic       ans_valid;
  logic [3:0] ans_d1;
  logic [3:0] ans_d2;
  logic [3:0] ans_d3;
  logic       ans_credit;
  // judge to controller
  logic               verdict_valid;
  quiz_pkg::verdict_t verdict;

  answer_entry answer_entry_inst (
    .CLK(CLK), .rst(rst), .state(state), .sel(sel), .clr(clr), .dec(dec),
    .q_valid(q_valid), .q_data(q_data), .ans_credit(ans_credit),
    .cnt1(cnt1), .cnt2(cnt2), .cnt3(cnt3), .q_level(q_level),
    .q_d1(q_d1), .q_d2(q_d2), .q_d3(q_d3), .q_loaded(q_loaded),
    .ans_valid(ans_valid), .ans_d1(ans_d1), .ans_d2(ans_d2), .ans_d3(ans_d3),
    .led(led)
  );

  answer_judge answer_judge_inst (
    .CLK(CLK), .rst(rst), .ans_valid(ans_valid),
    .ans_d1(ans_d1), .ans_d2(ans_d2), .ans_d3(ans_d3),
    .q_d1(q_d1), .q_d2(q_d2), .q_d3(q_d3),
    .verdict_valid(verdict_valid), .verdict(verdict), .hits(hits),
    .ans_credit(ans_credit)
  );

  game_ctrl game_ctrl_inst (
    .CLK(CLK), .rst(rst), .start(start), .q_loaded(q_loaded), .q_level(q_level),
    .verdict_valid(verdict_valid), .verdict(verdict),
    .state(state), .q_credit(q_credit), .tries(tries)
  );

  seg_display seg_display_inst (
    .CLK(CLK), .rst(rst), .state(state), .cnt1(cnt1), .cnt2(cnt2), .cnt3(cnt3),
    .q_d1(q_d1), .q_d2(q_d2), .q_d3(q_d3), .q_level(q_level),
    .seg1(seg1), .seg2(seg2), .seg3(seg3), .seg4(seg4), .seg5(seg5), .seg6(seg6),
    .seg_q1(seg_q1), .seg_q2(seg_q2), .seg_q3(seg_q3), .seg_lvl(seg_lvl)
  );

endmodule

// File: source/seg_display.sv
module seg_display (
  input  logic                   CLK,
  input  logic                   rst,
  input  quiz_pkg::game_state_t  state,
  input  logic [3:0]             cnt1,
  input  logic [3:0]             cnt2,
  input  logic [3:0]             cnt3,
  input  logic [3:0]             q_d1,
  input  logic [3:0]             q_d2,
  input  logic [3:0]             q_d3,
  input  logic [1:0]             q_level,
  output logic [3:0]             seg1,
  output logic [3:0]             seg2,
  output logic [3:0]             seg3,
  output logic [3:0]             seg4,
  output logic [3:0]             seg5,
  output logic [3:0]             seg6,
  output logic [3:0]             seg_q1,
  output logic [3:0]             seg_q2,
  output logic [3:0]             seg_q3,
  output logic [3:0]             seg_lvl
);

  // answer digits, each counter on a pair of nibbles
  always_ff @(posedge CLK) begin
    if (rst || state != quiz_pkg::INPUT) begin
      seg1 <= 4'd0;
      seg2 <= 4'd0;
      seg3 <= 4'd0;
      seg4 <= 4'd0;
      seg5 <= 4'd0;
      seg6 <= 4'd0;
    end else begin
      seg1 <= cnt1;
      seg2 <= cnt1;
      seg3 <= cnt2;
      seg4 <= cnt2;
      seg5 <= cnt3;
      seg6 <= cnt3;
    end
  end

  // question and level only during QUESTION
  // zero everywhere else hides the question
  always_ff @(posedge CLK) begin
    if (rst || state != quiz_pkg::QUESTION) begin
      seg_q1  <= 4'd0;
      seg_q2  <= 4'd0;
      seg_q3  <= 4'd0;
      seg_lvl <= 4'd0;
    end else begin
      seg_q1  <= q_d1;
      seg_q2  <= q_d2;
      seg_q3  <= q_d3;
      seg_lvl <= {2'b00, q_level};
    end
  end

endmodule

// File: source/game_ctrl.sv
`include "quiz_consts.svh"

module game_ctrl (
  input  logic                   CLK,
  input  logic                   rst,
  input  logic                   start,
  input  logic                   q_loaded,
  input  logic [1:0]             q_level,
  input  logic                   verdict_valid,
  input  quiz_pkg::verdict_t     verdict,
  output quiz_pkg::game_state_t  state,
  output logic                   q_credit,
  output logic [1:0]             tries
);

  // shared down counter for the show and result phases
  logic [`QZ_TMR_W-1:0] tmr;
  // show time for the held level
  logic [`QZ_TMR_W-1:0] show_len;
  logic tmr_done;
  logic tries_left;

  assign show_len   = `QZ_TMR_W'(`QZ_SHOW_BASE) >> q_level;
  assign tmr_done   = (tmr == '0);
  assign tries_left = (tries < 2'(`QZ_MAX_TRIES));

  // round FSM
  always_ff @(posedge CLK) begin
    if (rst) begin
      state    <= quiz_pkg::IDLE;
      q_credit <= 1'b0;
      tmr      <= '0;
    end else begin
      // one credit per round, in the first FETCH cycle
      q_credit <= (state == quiz_pkg::IDLE) && start;
      case (state)
        quiz_pkg::IDLE: begin
          if (start) begin
            state <= quiz_pkg::FETCH;
          end
        end
        // waits as long as the store takes
        quiz_pkg::FETCH: begin
          if (q_loaded) begin
            state <= quiz_pkg::QUESTION;
            tmr   <= show_len - `QZ_TMR_W'(1);
          end
        end
        quiz_pkg::QUESTION: begin
          if (tmr_done) begin
            state <= quiz_pkg::INPUT;
          end else begin
            tmr <= tmr - `QZ_TMR_W'(1);
          end
        end
        quiz_pkg::INPUT: begin
          if (verdict_valid) begin
            tmr <= `QZ_TMR_W'(`QZ_RESULT_CYCLES - 1);
            case (verdict)
              quiz_pkg::V_WIN:  state <= quiz_pkg::WIN;
              quiz_pkg::V_GOOD: state <= quiz_pkg::GOOD;
              default:          state <= quiz_pkg::OUCH;
            endcase
          end
        end
        // retry while tries remain, else lose
        quiz_pkg::OUCH, quiz_pkg::GOOD: begin
          if (!tmr_done) begin
            tmr <= tmr - `QZ_TMR_W'(1);
          end else if (tries_left) begin
            state <= quiz_pkg::INPUT;
          end else begin
            state <= quiz_pkg::LOSE;
            tmr   <= `QZ_TMR_W'(`QZ_RESULT_CYCLES - 1);
          end
        end
        quiz_pkg::WIN, quiz_pkg::LOSE: begin
          if (tmr_done) begin
            state <= quiz_pkg::IDLE;
          end else begin
            tmr <= tmr - `QZ_TMR_W'(1);
          end
        end
        default: begin
          state <= quiz_pkg::IDLE;
        end
      endcase
    end
  end

  // tries used in this round
  always_ff @(posedge CLK) begin
    if (rst || state == quiz_pkg::FETCH) begin
      tries <= 2'd0;
    end else if (verdict_valid) begin
      tries <= tries + 2'd1;
    end
  end

endmodule

// File: source/answer_judge.sv
module answer_judge (
  input  logic                CLK,
  input  logic                rst,
  input  logic                ans_valid,
  input  logic [3:0]          ans_d1,
  input  logic [3:0]          ans_d2,
  input  logic [3:0]          ans_d3,
  input  logic [3:0]          q_d1,
  input  logic [3:0]          q_d2,
  input  logic [3:0]          q_d3,
  output logic                verdict_valid,
  output quiz_pkg::verdict_t  verdict,
  output logic [1:0]          hits,
  output logic                ans_credit
);

  // per position match
  logic hit1;
  logic hit2;
  logic hit3;
  // number of digits in place, 0 to 3
  logic [1:0] hit_sum;
  quiz_pkg::verdict_t verdict_nxt;

  assign hit1 = (ans_d1 == q_d1);
  assign hit2 = (ans_d2 == q_d2);
  assign hit3 = (ans_d3 == q_d3);

  assign hit_sum = {1'b0, hit1} + {1'b0, hit2} + {1'b0, hit3};

  // three hits win, none is ouch, the rest good
  always_comb begin
    case (hit_sum)
      2'd3: begin
        verdict_nxt = quiz_pkg::V_WIN;
      end
      2'd0: begin
        verdict_nxt = quiz_pkg::V_OUCH;
      end
      default: begin
        verdict_nxt = quiz_pkg::V_GOOD;
      end
    endcase
  end

  // verdict one cycle after the answer
  always_ff @(posedge CLK) begin
    if (rst) begin
      verdict_valid <= 1'b0;
    end else begin
      verdict_valid <= ans_valid;
    end
  end

  // result payload, only meaningful with verdict_valid
  always_ff @(posedge CLK) begin
    if (ans_valid) begin
      verdict <= verdict_nxt;
      hits    <= hit_sum;
    end
  end

  // credit back one cycle after the verdict
  always_ff @(posedge CLK) begin
    if (rst) begin
      ans_credit <= 1'b0;
    end else begin
      ans_credit <= verdict_valid;
    end
  end

endmodule

// File: source/answer_entry.sv
module answer_entry (
  input  logic                   CLK,
  input  logic                   rst,
  input  quiz_pkg::game_state_t  state,
  input  logic [2:0]             sel,
  input  logic                   clr,
  input  logic                   dec,
  input  logic                   q_valid,
  input  logic [15:0]            q_data,
  input  logic                   ans_credit,
  output logic [3:0]             cnt1,
  output logic [3:0]             cnt2,
  output logic [3:0]             cnt3,
  output logic [1:0]             q_level,
  output logic [3:0]             q_d1,
  output logic [3:0]             q_d2,
  output logic [3:0]             q_d3,
  output logic                   q_loaded,
  output logic                   ans_valid,
  output logic [3:0]             ans_d1,
  output logic [3:0]             ans_d2,
  output logic [3:0]             ans_d3,
  output logic                   led
);

  // answer credit towards the judge, one only
  logic ans_cred;
  // question accepted this cycle
  logic q_accept;
  logic in_input;
  logic in_result;

  // digit step: blank goes to 1, 9 wraps back to 1
  function automatic logic [3:0] step_digit(input logic [3:0] d);
    logic [3:0] nxt;
    if (d == 4'd0 || d == 4'd9) begin
      nxt = 4'd1;
    end else begin
      nxt = d + 4'd1;
    end
    return nxt;
  endfunction

  assign in_input  = (state == quiz_pkg::INPUT);
  assign in_result = (state == quiz_pkg::OUCH) || (state == quiz_pkg::GOOD) ||
                     (state == quiz_pkg::WIN)  || (state == quiz_pkg::LOSE);

  // only in FETCH, and only while nothing is held yet
  // a repeat q_valid after the load is dropped here
  assign q_accept = q_valid && (state == quiz_pkg::FETCH) && !led;

  // question hold, led follows it
  always_ff @(posedge CLK) begin
    if (rst) begin
      led      <= 1'b0;
      q_loaded <= 1'b0;
    end else begin
      q_loaded <= q_accept;
      if (q_accept) begin
        led <= 1'b1;
      end else if (state == quiz_pkg::WIN || state == quiz_pkg::LOSE) begin
        led <= 1'b0;
      end
    end
  end

  // question payload, d1 is the ones digit as on the board
  // upper two level bits dropped
  always_ff @(posedge CLK) begin
    if (q_accept) begin
      q_level <= q_data[13:12];
      q_d3    <= q_data[11:8];
      q_d2    <= q_data[7:4];
      q_d1    <= q_data[3:0];
    end
  end

  // digit counters
  // sel[0] over sel[1] over sel[2] over clr
  always_ff @(posedge CLK) begin
    if (rst || in_result) begin
      cnt1 <= 4'd0;
      cnt2 <= 4'd0;
      cnt3 <= 4'd0;
    end else if (in_input) begin
      if (sel[0]) begin
        cnt1 <= step_digit(cnt1);
      end else if (sel[1]) begin
        cnt2 <= step_digit(cnt2);
      end else if (sel[2]) begin
        cnt3 <= step_digit(cnt3);
      end else if (clr) begin
        cnt1 <= 4'd0;
        cnt2 <= 4'd0;
        cnt3 <= 4'd0;
      end
    end
  end

  // submit goes straight to the judge in the dec cycle
  assign ans_valid = in_input && dec && ans_cred;
  assign ans_d1    = cnt1;
  assign ans_d2    = cnt2;
  assign ans_d3    = cnt3;

  // spent on submit, handed back by the judge
  always_ff @(posedge CLK) begin
    if (rst) begin
      ans_cred <= 1'b1;
    end else if (ans_valid) begin
      ans_cred <= 1'b0;
    end else if (ans_credit) begin
      ans_cred <= 1'b1;
    end
  end

endmodule

// File: source/quiz_pkg.sv
`include "quiz_consts.svh"

package quiz_pkg;

  // round states
  // codes 0001, 0101..0111 and 11xx are unused
  typedef enum logic [3:0] {
    // waiting for start
    IDLE     = `QZ_ST_IDLE,
    // credit sent, waiting on the question store
    FETCH    = `QZ_ST_FETCH,
    // question on display
    QUESTION = `QZ_ST_QUESTION,
    // player enters digits
    INPUT    = `QZ_ST_INPUT,
    // no digit in place
    OUCH     = `QZ_ST_OUCH,
    // one or two digits in place
    GOOD     = `QZ_ST_GOOD,
    // all three in place
    WIN      = `QZ_ST_WIN,
    // tries used up
    LOSE     = `QZ_ST_LOSE
  } game_state_t;

  // judge outcome for one submitted answer
  typedef enum logic [1:0] {
    V_OUCH = 2'd0,
    V_GOOD = 2'd1,
    V_WIN  = 2'd2
  } verdict_t;

endpackage

// File: source/quiz_consts.svh
`ifndef QUIZ_CONSTS_SVH
`define QUIZ_CONSTS_SVH

// attempts allowed per round
`define QZ_MAX_TRIES 3

// question display time at level 0, halved per level step
`define QZ_SHOW_BASE 16
// hold time of each result state
`define QZ_RESULT_CYCLES 8
// width of the show and result timers
`define QZ_TMR_W 5

// state encodings, kept from the board version
`define QZ_ST_IDLE     4'b0000
`define QZ_ST_FETCH    4'b0010
`define QZ_ST_QUESTION 4'b0011
`define QZ_ST_INPUT    4'b0100
`define QZ_ST_OUCH     4'b1000
`define QZ_ST_GOOD     4'b1001
`define QZ_ST_WIN      4'b1010
`define QZ_ST_LOSE     4'b1011

`endif
